// ==== include/rv_defines.svh ====
// widths, register count, pc step and core-mapped store addresses
`ifndef RV_DEFINES_SVH
`define RV_DEFINES_SVH

// data path and address widths
`define RV_XLEN         32
`define RV_ADDR_W       32

// register file geometry
`define RV_NUM_REGS     32
`define RV_REG_SEL_W    5

// pc advances one word per instruction
`define RV_INSTR_BYTES  32'd4

// stores to these addresses never reach memory
`define RV_OUT_ADDR     32'd1000
`define RV_HALT_ADDR    32'd1004

`endif

// ==== src/rv_isa_pkg.sv ====
// rv32i encoding types: opcodes, funct3 codes, funct7/funct3 pairs, register index
`default_nettype none

`include "rv_defines.svh"

package rv_isa_pkg;

    // major opcodes of the kept instruction groups
    typedef enum logic [6:0] {
        OPIMM  = 7'b0010011,
        LOAD   = 7'b0000011,
        STORE  = 7'b0100011,
        BRANCH = 7'b1100011,
        OP     = 7'b0110011,
        LUI    = 7'b0110111,
        AUIPC  = 7'b0010111
    } opcode_e;

    // funct3 values overlap between opcode groups, so these are plain constants
    typedef logic [2:0] funct3_e;

    localparam funct3_e F3_ADDI = 3'b000;
    localparam funct3_e F3_BEQ  = 3'b000;
    localparam funct3_e F3_BNE  = 3'b001;

    // {funct7, funct3} of the register-register group
    typedef enum logic [9:0] {
        OPF_ADD  = 10'b0000000_000,
        OPF_SUB  = 10'b0100000_000,
        OPF_SLL  = 10'b0000000_001,
        OPF_SLT  = 10'b0000000_010,
        OPF_SLTU = 10'b0000000_011,
        OPF_XOR  = 10'b0000000_100,
        OPF_SRL  = 10'b0000000_101,
        OPF_SRA  = 10'b0100000_101,
        OPF_OR   = 10'b0000000_110,
        OPF_AND  = 10'b0000000_111
    } op_funct_e;

    typedef logic [`RV_REG_SEL_W-1:0] reg_sel_t;

endpackage

`default_nettype wire

// ==== src/rv_core_pkg.sv ====
// core types: data word, sequencer state, execute action, alu operation
`default_nettype none

`include "rv_defines.svh"

package rv_core_pkg;

    typedef logic [`RV_XLEN-1:0] word_t;

    // one instruction in flight, so four states are enough
    typedef enum logic [1:0] {
        FETCH,
        EXEC,
        MEM_WAIT,
        HALTED
    } seq_state_e;

    // what the sequencer does once the instruction word is acknowledged
    typedef enum logic [2:0] {
        NEXT,
        LOAD,
        STORE,
        OUT,
        HALT
    } action_e;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLL,
        ALU_SRL,
        ALU_SRA,
        ALU_SLT,
        ALU_SLTU
    } alu_op_e;

endpackage

`default_nettype wire

// ==== src/decode_if.sv ====
// decoded instruction fields shared by decoder, execute unit and register file
`timescale 1ns/1ns
`default_nettype none

interface decode_if;

    rv_isa_pkg::opcode_e   op;
    rv_isa_pkg::funct3_e   funct3;
    rv_isa_pkg::op_funct_e op_funct;
    rv_isa_pkg::reg_sel_t  rd;
    rv_isa_pkg::reg_sel_t  rs1;
    rv_isa_pkg::reg_sel_t  rs2;
    rv_core_pkg::word_t    i_imm;
    rv_core_pkg::word_t    s_imm;
    rv_core_pkg::word_t    b_imm;
    rv_core_pkg::word_t    u_imm;

    modport decoder (
        output op, funct3, op_funct, rd, rs1, rs2, i_imm, s_imm, b_imm, u_imm
    );

    modport execute (
        input op, funct3, op_funct, rd, rs1, rs2, i_imm, s_imm, b_imm, u_imm
    );

    // register file only needs the source indexes
    modport regsel (input rs1, rs2);

endinterface

`default_nettype wire

// ==== src/rv_decoder.sv ====
// instruction word field split and immediate sign extension
`timescale 1ns/1ns
`default_nettype none

`include "rv_defines.svh"

module rv_decoder (
    input  rv_core_pkg::word_t instr,
    decode_if.decoder          dec
);

    logic sign;

    assign sign = instr[31];

    // fixed field positions of the base encoding
    assign dec.op       = rv_isa_pkg::opcode_e'(instr[6:0]);
    assign dec.funct3   = rv_isa_pkg::funct3_e'(instr[14:12]);
    assign dec.op_funct = rv_isa_pkg::op_funct_e'({instr[31:25], instr[14:12]});
    assign dec.rd       = instr[11:7];
    assign dec.rs1      = instr[19:15];
    assign dec.rs2      = instr[24:20];

    // I-type: addi, loads
    assign dec.i_imm = {{(`RV_XLEN-12){sign}}, instr[31:20]};

    // S-type splits the offset around rd position
    assign dec.s_imm = {{(`RV_XLEN-12){sign}}, instr[31:25], instr[11:7]};

    // B-type offset is in half-words, bit 0 is always zero
    assign dec.b_imm = {
        {(`RV_XLEN-13){sign}},
        instr[31],
        instr[7],
        instr[30:25],
        instr[11:8],
        1'b0
    };

    // U-type fills the upper 20 bits
    assign dec.u_imm = {instr[31:12], {(`RV_XLEN-20){1'b0}}};

endmodule

`default_nettype wire

// ==== src/rv_regfile.sv ====
// 32-entry register file, two async read ports, one write port, x0 reads zero
`timescale 1ns/1ns
`default_nettype none

`include "rv_defines.svh"

module rv_regfile (
    input  logic                 clk,
    input  logic                 rst,
    decode_if.regsel             sel,
    output rv_core_pkg::word_t   rs1_data,
    output rv_core_pkg::word_t   rs2_data,
    input  logic                 wr_en,
    input  rv_isa_pkg::reg_sel_t wr_sel,
    input  rv_core_pkg::word_t   wr_data
);

    rv_core_pkg::word_t regs [`RV_NUM_REGS];

    assign rs1_data = regs[sel.rs1];
    assign rs2_data = regs[sel.rs2];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < `RV_NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en && (wr_sel != '0)) begin
            // x0 is never written, so it keeps its reset value
            regs[wr_sel] <= wr_data;
        end
    end

endmodule

`default_nettype wire

// ==== src/rv_execute.sv ====
// alu, branch compare, load/store address and action select for one instruction
`timescale 1ns/1ns
`default_nettype none

`include "rv_defines.svh"

module rv_execute (
    decode_if.execute             dec,
    input  rv_core_pkg::word_t    rs1_data,
    input  rv_core_pkg::word_t    rs2_data,
    input  rv_core_pkg::word_t    pc,
    output rv_core_pkg::action_e  action,
    output rv_core_pkg::word_t    result,
    output logic                  rd_wr,
    output rv_core_pkg::word_t    next_pc,
    output rv_core_pkg::word_t    mem_addr_calc,
    output rv_core_pkg::word_t    store_data
);

    rv_core_pkg::alu_op_e alu_op;
    rv_core_pkg::word_t   alu_a;
    rv_core_pkg::word_t   alu_b;
    rv_core_pkg::word_t   seq_pc;
    logic                 rs_equal;

    assign seq_pc     = pc + `RV_INSTR_BYTES;
    assign rs_equal   = (rs1_data == rs2_data);
    assign store_data = rs2_data;

    // stores use the split S offset, loads the I offset
    assign mem_addr_calc = rs1_data +
        ((dec.op == rv_isa_pkg::STORE) ? dec.s_imm : dec.i_imm);

    always_comb begin
        action  = rv_core_pkg::NEXT;
        alu_op  = rv_core_pkg::ALU_ADD;
        alu_a   = rs1_data;
        alu_b   = dec.i_imm;
        rd_wr   = 1'b0;
        next_pc = seq_pc;
        case (dec.op)
            rv_isa_pkg::OPIMM: begin
                if (dec.funct3 == rv_isa_pkg::F3_ADDI) begin
                    rd_wr = 1'b1;
                end else begin
                    action = rv_core_pkg::HALT;
                end
            end
            rv_isa_pkg::OP: begin
                alu_b = rs2_data;
                rd_wr = 1'b1;
                case (dec.op_funct)
                    rv_isa_pkg::OPF_ADD:  alu_op = rv_core_pkg::ALU_ADD;
                    rv_isa_pkg::OPF_SUB:  alu_op = rv_core_pkg::ALU_SUB;
                    rv_isa_pkg::OPF_AND:  alu_op = rv_core_pkg::ALU_AND;
                    rv_isa_pkg::OPF_OR:   alu_op = rv_core_pkg::ALU_OR;
                    rv_isa_pkg::OPF_XOR:  alu_op = rv_core_pkg::ALU_XOR;
                    rv_isa_pkg::OPF_SLL:  alu_op = rv_core_pkg::ALU_SLL;
                    rv_isa_pkg::OPF_SRL:  alu_op = rv_core_pkg::ALU_SRL;
                    rv_isa_pkg::OPF_SRA:  alu_op = rv_core_pkg::ALU_SRA;
                    rv_isa_pkg::OPF_SLT:  alu_op = rv_core_pkg::ALU_SLT;
                    rv_isa_pkg::OPF_SLTU: alu_op = rv_core_pkg::ALU_SLTU;
                    default: begin
                        rd_wr  = 1'b0;
                        action = rv_core_pkg::HALT;
                    end
                endcase
            end
            rv_isa_pkg::LUI: begin
                alu_a = '0;
                alu_b = dec.u_imm;
                rd_wr = 1'b1;
            end
            rv_isa_pkg::AUIPC: begin
                alu_a = pc;
                alu_b = dec.u_imm;
                rd_wr = 1'b1;
            end
            rv_isa_pkg::LOAD: action = rv_core_pkg::LOAD;
            rv_isa_pkg::STORE: begin
                // two addresses are handled by the core itself
                if (mem_addr_calc == `RV_OUT_ADDR) begin
                    action = rv_core_pkg::OUT;
                end else if (mem_addr_calc == `RV_HALT_ADDR) begin
                    action = rv_core_pkg::HALT;
                end else begin
                    action = rv_core_pkg::STORE;
                end
            end
            rv_isa_pkg::BRANCH: begin
                if (dec.funct3 == rv_isa_pkg::F3_BEQ) begin
                    next_pc = rs_equal ? (pc + dec.b_imm) : seq_pc;
                end else if (dec.funct3 == rv_isa_pkg::F3_BNE) begin
                    next_pc = rs_equal ? seq_pc : (pc + dec.b_imm);
                end else begin
                    action = rv_core_pkg::HALT;
                end
            end
            default: action = rv_core_pkg::HALT;
        endcase
    end

    // shift amount is the low five bits of operand b
    always_comb begin
        case (alu_op)
            rv_core_pkg::ALU_ADD:  result = alu_a + alu_b;
            rv_core_pkg::ALU_SUB:  result = alu_a - alu_b;
            rv_core_pkg::ALU_AND:  result = alu_a & alu_b;
            rv_core_pkg::ALU_OR:   result = alu_a | alu_b;
            rv_core_pkg::ALU_XOR:  result = alu_a ^ alu_b;
            rv_core_pkg::ALU_SLL:  result = alu_a << alu_b[4:0];
            rv_core_pkg::ALU_SRL:  result = alu_a >> alu_b[4:0];
            rv_core_pkg::ALU_SRA:  result = $signed(alu_a) >>> alu_b[4:0];
            rv_core_pkg::ALU_SLT:  result = rv_core_pkg::word_t'($signed(alu_a) < $signed(alu_b));
            rv_core_pkg::ALU_SLTU: result = rv_core_pkg::word_t'(alu_a < alu_b);
            default:               result = '0;
        endcase
    end

endmodule

`default_nettype wire

// ==== src/rv_sequencer.sv ====
// fetch/execute/memory-wait fsm, pc, memory port and write-back control
`timescale 1ns/1ns
`default_nettype none

module rv_sequencer (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  mem_ack,
    input  rv_core_pkg::word_t    mem_rd_data,
    input  rv_core_pkg::action_e  action,
    input  rv_core_pkg::word_t    result,
    input  rv_core_pkg::word_t    next_pc,
    input  rv_core_pkg::word_t    mem_addr_calc,
    input  rv_core_pkg::word_t    store_data,
    input  logic                  rd_wr,
    input  rv_isa_pkg::reg_sel_t  rd,
    output rv_core_pkg::word_t    pc,
    output rv_core_pkg::word_t    instr,
    output rv_core_pkg::word_t    mem_addr,
    output logic                  mem_rd_req,
    output logic                  mem_wr_req,
    output rv_core_pkg::word_t    mem_wr_data,
    output logic                  wr_en,
    output rv_isa_pkg::reg_sel_t  wr_sel,
    output rv_core_pkg::word_t    wr_data,
    output rv_core_pkg::word_t    out,
    output logic                  outen,
    output logic                  halt
);

    rv_core_pkg::seq_state_e state;
    rv_core_pkg::seq_state_e state_n;
    rv_core_pkg::word_t      pc_n;
    logic                    load_pending;
    logic                    load_pending_n;
    rv_isa_pkg::reg_sel_t    load_rd;

    // the instruction word arrives on the read data bus in the ack cycle
    assign instr       = mem_rd_data;
    assign mem_wr_data = store_data;
    assign out         = store_data;
    assign halt        = (state == rv_core_pkg::HALTED);

    always_comb begin
        state_n        = state;
        pc_n           = pc;
        load_pending_n = load_pending;
        mem_addr       = pc;
        mem_rd_req     = 1'b0;
        mem_wr_req     = 1'b0;
        wr_en          = 1'b0;
        wr_sel         = rd;
        wr_data        = result;
        outen          = 1'b0;
        case (state)
            rv_core_pkg::FETCH: begin
                mem_rd_req = 1'b1;
                state_n    = rv_core_pkg::EXEC;
            end
            rv_core_pkg::EXEC: begin
                if (mem_ack) begin
                    case (action)
                        rv_core_pkg::NEXT, rv_core_pkg::OUT: begin
                            wr_en      = rd_wr;
                            outen      = (action == rv_core_pkg::OUT);
                            pc_n       = next_pc;
                            mem_addr   = next_pc;
                            mem_rd_req = 1'b1;
                        end
                        rv_core_pkg::LOAD, rv_core_pkg::STORE: begin
                            // pc moves on now, the fetch waits for the data ack
                            pc_n           = next_pc;
                            mem_addr       = mem_addr_calc;
                            mem_rd_req     = (action == rv_core_pkg::LOAD);
                            mem_wr_req     = (action == rv_core_pkg::STORE);
                            load_pending_n = (action == rv_core_pkg::LOAD);
                            state_n        = rv_core_pkg::MEM_WAIT;
                        end
                        default: state_n = rv_core_pkg::HALTED;
                    endcase
                end
            end
            rv_core_pkg::MEM_WAIT: begin
                if (mem_ack) begin
                    wr_en      = load_pending;
                    wr_sel     = load_rd;
                    wr_data    = mem_rd_data;
                    mem_rd_req = 1'b1;
                    state_n    = rv_core_pkg::EXEC;
                end
            end
            default: begin
                // halted, no more requests
            end
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state        <= rv_core_pkg::FETCH;
            pc           <= '0;
            load_pending <= 1'b0;
        end else begin
            state        <= state_n;
            pc           <= pc_n;
            load_pending <= load_pending_n;
        end
    end

    // destination of an outstanding load
    always_ff @(posedge clk) begin
        if (state == rv_core_pkg::EXEC && mem_ack) begin
            load_rd <= rd;
        end
    end

endmodule

`default_nettype wire

// ==== src/proc.sv ====
// core top level: decoder, register file, execute unit and sequencer
`timescale 1ns/1ns
`default_nettype none

`include "rv_defines.svh"

module proc (
    input  logic                    clk,
    input  logic                    rst,
    output logic [`RV_ADDR_W-1:0]   mem_addr,
    input  rv_core_pkg::word_t      mem_rd_data,
    output rv_core_pkg::word_t      mem_wr_data,
    output logic                    mem_rd_req,
    output logic                    mem_wr_req,
    input  logic                    mem_ack,
    output rv_core_pkg::word_t      out,
    output logic                    outen,
    output logic                    halt
);

    rv_core_pkg::word_t   instr;
    rv_core_pkg::word_t   pc;
    rv_core_pkg::word_t   rs1_data;
    rv_core_pkg::word_t   rs2_data;
    rv_core_pkg::action_e action;
    rv_core_pkg::word_t   result;
    logic                 rd_wr;
    rv_core_pkg::word_t   next_pc;
    rv_core_pkg::word_t   mem_addr_calc;
    rv_core_pkg::word_t   store_data;
    logic                 wr_en;
    rv_isa_pkg::reg_sel_t wr_sel;
    rv_core_pkg::word_t   wr_data;

    decode_if dec_bus ();

    rv_decoder u_decoder (
        .instr (instr),
        .dec   (dec_bus.decoder)
    );

    rv_regfile u_regfile (
        .clk      (clk),
        .rst      (rst),
        .sel      (dec_bus.regsel),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .wr_en    (wr_en),
        .wr_sel   (wr_sel),
        .wr_data  (wr_data)
    );

    rv_execute u_execute (
        .dec           (dec_bus.execute),
        .rs1_data      (rs1_data),
        .rs2_data      (rs2_data),
        .pc            (pc),
        .action        (action),
        .result        (result),
        .rd_wr         (rd_wr),
        .next_pc       (next_pc),
        .mem_addr_calc (mem_addr_calc),
        .store_data    (store_data)
    );

    rv_sequencer u_sequencer (
        .clk           (clk),
        .rst           (rst),
        .mem_ack       (mem_ack),
        .mem_rd_data   (mem_rd_data),
        .action        (action),
        .result        (result),
        .next_pc       (next_pc),
        .mem_addr_calc (mem_addr_calc),
        .store_data    (store_data),
        .rd_wr         (rd_wr),
        .rd            (dec_bus.rd),
        .pc            (pc),
        .instr         (instr),
        .mem_addr      (mem_addr),
        .mem_rd_req    (mem_rd_req),
        .mem_wr_req    (mem_wr_req),
        .mem_wr_data   (mem_wr_data),
        .wr_en         (wr_en),
        .wr_sel        (wr_sel),
        .wr_data       (wr_data),
        .out           (out),
        .outen         (outen),
        .halt          (halt)
    );

endmodule

`default_nettype wire

// ==== tests/tb_clock.sv ====
// testbench clock and reset generator
`timescale 1ns/1ns
`default_nettype none

module tb_clock #(
    parameter int PERIOD       = 8,
    parameter int RESET_CYCLES = 4
) (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever begin
            #(PERIOD / 2) clk = ~clk;
        end
    end

    // reset is released on a falling edge as well
    initial begin
        rst = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
    end

endmodule

`default_nettype wire

// ==== tests/proc_tb.sv ====
// testbench top: word memory model, golden image loader, output/memory/halt checks
`timescale 1ns/1ns
`default_nettype none

module proc_tb;

    localparam int MEM_WORDS    = 128;
    localparam int GOLDEN_WORDS = 256;
    localparam int COUNT_IDX    = 128;
    localparam int OUT_IDX      = 129;
    localparam int MAX_CYCLES   = 4000;
    localparam int RESET_LIMIT  = 20;
    localparam int IDLE_LIMIT   = 12;
    localparam int QUIET_CYCLES = 20;

    logic               clk;
    logic               rst;
    rv_core_pkg::word_t mem_addr;
    rv_core_pkg::word_t mem_rd_data;
    rv_core_pkg::word_t mem_wr_data;
    logic               mem_rd_req;
    logic               mem_wr_req;
    logic               mem_ack;
    rv_core_pkg::word_t out;
    logic               outen;
    logic               halt;

    rv_core_pkg::word_t golden [GOLDEN_WORDS];
    rv_core_pkg::word_t mem [MEM_WORDS];

    // the single outstanding request of the memory model
    logic               busy;
    logic               req_write;
    rv_core_pkg::word_t req_addr;
    rv_core_pkg::word_t req_data;
    int                 delay_left;
    integer             seed;
    int                 out_count;
    int                 exp_count;
    int                 idle_cycles;
    logic               done;

    tb_clock #(.PERIOD(8), .RESET_CYCLES(4)) u_clock (
        .clk (clk),
        .rst (rst)
    );

    proc dut (
        .clk         (clk),
        .rst         (rst),
        .mem_addr    (mem_addr),
        .mem_rd_data (mem_rd_data),
        .mem_wr_data (mem_wr_data),
        .mem_rd_req  (mem_rd_req),
        .mem_wr_req  (mem_wr_req),
        .mem_ack     (mem_ack),
        .out         (out),
        .outen       (outen),
        .halt        (halt)
    );

    task automatic end_with_failure();
        $display("Simulation finished: FAIL");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_out(input rv_core_pkg::word_t got, input rv_core_pkg::word_t exp);
        if (got !== exp) begin
            $display("Error: out = 0x%08h, expected 0x%08h (output %0d)", got, exp, out_count);
            end_with_failure();
        end
    endtask

    task automatic check_mem(input rv_core_pkg::word_t addr, input rv_core_pkg::word_t exp);
        if (addr >= rv_core_pkg::word_t'(MEM_WORDS * 4)) begin
            $display("golden memory address 0x%08h lies outside the memory model", addr);
            end_with_failure();
        end
        if (mem[addr[8:2]] !== exp) begin
            $display("Error: mem[0x%08h] = 0x%08h, expected 0x%08h",
                     addr, mem[addr[8:2]], exp);
            end_with_failure();
        end
    endtask

    task automatic check_halt(input logic got, input logic exp);
        if (got !== exp) begin
            $display("Error: halt = 0x%h, expected 0x%h", got, exp);
            end_with_failure();
        end
    endtask

    // ack side of the memory model, called on the falling edge
    task automatic drive_ack();
        if (busy && delay_left == 0) begin
            if (req_write) begin
                mem[req_addr[8:2]] = req_data;
            end
            mem_ack     = 1'b1;
            mem_rd_data = mem[req_addr[8:2]];
            busy        = 1'b0;
        end else begin
            mem_ack     = 1'b0;
            mem_rd_data = '0;
            if (busy) begin
                delay_left--;
            end
        end
    endtask

    // request side, sampled once the core outputs have settled
    task automatic take_request();
        if (mem_rd_req || mem_wr_req) begin
            if (busy) begin
                $display("new memory request while another one is outstanding");
                end_with_failure();
            end
            if (mem_rd_req && mem_wr_req) begin
                $display("read and write requested in the same cycle");
                end_with_failure();
            end
            if (mem_addr[1:0] != 2'b00 || mem_addr >= rv_core_pkg::word_t'(MEM_WORDS * 4)) begin
                $display("request address 0x%08h is unaligned or outside the memory", mem_addr);
                end_with_failure();
            end
            busy        = 1'b1;
            req_write   = mem_wr_req;
            req_addr    = mem_addr;
            req_data    = mem_wr_data;
            delay_left  = $random(seed) & 3;
            idle_cycles = 0;
        end else if (!busy) begin
            idle_cycles++;
        end
    endtask

    initial begin
        int cycles;
        int pair_idx;
        seed        = 96;
        mem_ack     = 1'b0;
        mem_rd_data = '0;
        busy        = 1'b0;
        req_write   = 1'b0;
        req_addr    = '0;
        req_data    = '0;
        delay_left  = 0;
        out_count   = 0;
        idle_cycles = 0;
        done        = 1'b0;

        // words the golden file leaves out keep an address-dependent pattern
        for (int i = 0; i < GOLDEN_WORDS; i++) begin
            golden[i] = 32'h5a5a_0000 ^ 32'(i);
        end
        $readmemh("tests/proc_golden.hex", golden);
        for (int i = 0; i < MEM_WORDS; i++) begin
            mem[i] = golden[i];
        end
        exp_count = int'(golden[COUNT_IDX]);
        if (exp_count < 0 || exp_count > GOLDEN_WORDS - OUT_IDX) begin
            $display("golden output count %0d is out of range", exp_count);
            end_with_failure();
        end

        cycles = 0;
        while (!done) begin
            @(negedge clk);
            drive_ack();
            #1;
            cycles++;
            if (cycles > MAX_CYCLES) begin
                $display("core did not halt within %0d cycles", MAX_CYCLES);
                end_with_failure();
            end
            if (rst) begin
                if (cycles > RESET_LIMIT) begin
                    $display("reset was not released in time");
                    end_with_failure();
                end
            end else if (halt === 1'b1) begin
                done = 1'b1;
            end else begin
                take_request();
                if (idle_cycles > IDLE_LIMIT) begin
                    $display("no memory request for %0d cycles while running", IDLE_LIMIT);
                    end_with_failure();
                end
                if (outen) begin
                    if (out_count >= exp_count) begin
                        $display("more output strobes than the %0d expected", exp_count);
                        end_with_failure();
                    end
                    check_out(out, golden[OUT_IDX + out_count]);
                    out_count++;
                end
            end
        end

        // halted core stays quiet
        for (int n = 0; n < QUIET_CYCLES; n++) begin
            @(negedge clk);
            drive_ack();
            #1;
            if (mem_rd_req || mem_wr_req) begin
                $display("memory request to 0x%08h after halt", mem_addr);
                end_with_failure();
            end
            if (outen) begin
                $display("output strobe after halt");
                end_with_failure();
            end
            check_halt(halt, 1'b1);
        end

        if (out_count != exp_count) begin
            $display("Error: outen count = 0x%0h, expected 0x%0h", out_count, exp_count);
            end_with_failure();
        end

        // address/value pairs up to the all-ones end marker
        pair_idx = OUT_IDX + exp_count;
        while (golden[pair_idx] != 32'hffff_ffff) begin
            if (pair_idx + 1 >= GOLDEN_WORDS) begin
                $display("golden memory list has no end marker");
                end_with_failure();
            end
            check_mem(golden[pair_idx], golden[pair_idx + 1]);
            pair_idx += 2;
        end

        $display("Simulation finished: PASS");
        $finish;
    end

endmodule

`default_nettype wire

// ==== proc.f ====
+incdir+include
src/rv_isa_pkg.sv
src/rv_core_pkg.sv
src/decode_if.sv
src/rv_decoder.sv
src/rv_regfile.sv
src/rv_execute.sv
src/rv_sequencer.sv
src/proc.sv
tests/tb_clock.sv
tests/proc_tb.sv

// ==== Makefile ====
# Verilator build and run of the proc testbench

LOG := sim.log

.PHONY: help test clean

help:
	@echo "make test   build with Verilator, run the testbench, check the log"
	@echo "make clean  remove the build directory and the log"
	@echo "make help   show this list"

test:
	verilator --binary --timing -j 0 --top-module proc_tb -f proc.f -Mdir obj_dir -o proc_sim
	-./obj_dir/proc_sim > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "Simulation finished: FAIL" $(LOG); then exit 1; fi
	@grep -q "Simulation finished: PASS" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// ==== tests/proc_golden.hex ====
// words from 0: program, from 0x60: data, at 0x80: output count, then expected outputs
// in order, then data address/value pairs checked after halt, closed by address ffffffff
@000
ff800093 03500113 00400213 3e102423  // x1=-8 x2=53 x4=4, out x1
002081b3 3e302423 401101b3 3e302423  // add, sub
0020f1b3 3e302423 0020e1b3 3e302423  // and, or
0020c1b3 3e302423 004091b3 3e302423  // xor, sll
0040d1b3 3e302423 4040d1b3 3e302423  // srl, sra
0020a1b3 3e302423 0020b1b3 3e302423  // slt, sltu with negative rs1
001121b3 3e302423 001131b3 3e302423  // slt, sltu with negative rs2
18000293 12345337 3e602423 67830313  // x5=0x180, lui, out, addi
0062a023 0002a383 3e702423 0012a223  // store, load back, out, store at +4
0042a403 3e802423 0082a483 3e902423  // load +4, out, load preset word, out
00300513 3ea02423 fff50513 fe051ce3  // bne countdown from 3
00000463 3e102423 00250463 3e202423  // beq taken over an out, beq not taken
00001597 3eb02423 fedcb637 3ec02423  // auipc at 0xc0, lui
00500013 3e002423 3e002623           // write x0, out x0, halt
@060
11111111 22222222 cafef00d
@080
00000018
fffffff8 0000002d 0000003d 00000030
fffffffd ffffffcd ffffff80 0fffffff
ffffffff 00000001 00000000 00000000
00000001 12345000 12345678 fffffff8
cafef00d 00000003 00000002 00000001
00000035 000010c0 fedcb000 00000000
00000180 12345678 00000184 fffffff8 00000188 cafef00d
ffffffff
